// File: logic/aprsc_bus_pkg.sv
// register map and bus widths of the predictor coprocessor
// imported by the bus-side modules and the top level
package aprsc_bus_pkg;

	//----------------------------------------------------------------------
	// bus widths
	//----------------------------------------------------------------------
	localparam int BUS_DW = 32;	// wishbone data width
	localparam int ADR_W  = 16;	// low address bits that are decoded

	//----------------------------------------------------------------------
	// register sub-addresses
	//----------------------------------------------------------------------
	localparam logic [ADR_W-1:0] ADR_REQ    = 16'h0000;	// w, bit 0 request level
	localparam logic [ADR_W-1:0] ADR_TR     = 16'h0004;	// w, bit 0 trigger level
	localparam logic [ADR_W-1:0] ADR_DQ     = 16'h0008;	// w, bits 15:0 sample
	localparam logic [ADR_W-1:0] ADR_STATUS = 16'h000C;	// r, bit 0 done flag
	localparam logic [ADR_W-1:0] ADR_SE     = 16'h0010;	// r, signal estimate
	localparam logic [ADR_W-1:0] ADR_SR     = 16'h0014;	// r, reconstructed signal

	// returned for any address not in the map
	localparam logic [BUS_DW-1:0] RD_DEFAULT = 32'hDEAD_BEEF;

endpackage

// File: logic/aprsc_dsp_pkg.sv
// number formats and constants of the adaptive zero predictor
// samples and coefficients are linear two's complement words
// coefficients carry COEF_FRAC fraction bits
package aprsc_dsp_pkg;

	//----------------------------------------------------------------------
	// word widths
	//----------------------------------------------------------------------
	localparam int SAMPLE_W  = 16;	// dq, se and sr
	localparam int ACC_W     = 20;	// mac accumulator, headroom for 6 taps
	localparam int COEF_FRAC = 14;	// b_k = 1.0 is 2**14

	//----------------------------------------------------------------------
	// predictor shape
	//----------------------------------------------------------------------
	localparam int NUM_TAPS  = 6;	// sixth-order zero predictor
	localparam int TAP_IDX_W = 3;	// enough for tap index 0..5

	// sign-sign adaptation, fixed leakage
	localparam int UPD_GAIN   = 128;	// step added or removed per update
	localparam int LEAK_SHIFT = 8;	// b_k loses b_k/256 per update

	//----------------------------------------------------------------------
	// types
	//----------------------------------------------------------------------
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SAMPLE_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

endpackage

// File: logic/aprsc_bus_regs.sv
// bus input side of the coprocessor
// acknowledges each access once, one cycle after it starts, and applies
// writes to the request, trigger and sample registers in the ack cycle
module aprsc_bus_regs
	import aprsc_bus_pkg::*;
	import aprsc_dsp_pkg::*;
(
	input  logic              CoPrclk_int,
	input  logic              reset,
	input  logic [ADR_W-1:0]  i_wb_adr,
	input  logic              i_wb_we,
	input  logic [BUS_DW-1:0] i_wb_dat,
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	output logic              o_wb_ack,
	output logic              o_req,
	output logic              o_tr,
	output sample_t           o_dq,
	output logic              o_rd_stb
);

	logic access;	// master is addressing us
	logic seen;	// current access already answered
	logic first;	// first cycle of an access

	assign access   = i_wb_cyc & i_wb_stb;
	assign first    = access & ~seen;
	assign o_rd_stb = first & ~i_wb_we;	// readback loads with ack

	always_ff @(posedge CoPrclk_int or posedge reset) begin
		if (reset) begin
			seen     <= 1'b0;
			o_wb_ack <= 1'b0;
			o_req    <= 1'b0;
			o_tr     <= 1'b0;
			o_dq     <= '0;
		end else begin
			seen     <= access;	// held until cyc/stb drop
			o_wb_ack <= first;
			if (first & i_wb_we) begin
				case (i_wb_adr)
					ADR_REQ: o_req <= i_wb_dat[0];
					ADR_TR:  o_tr  <= i_wb_dat[0];
					ADR_DQ:  o_dq  <= sample_t'(i_wb_dat[SAMPLE_W-1:0]);
					default: ;	// read-only or unmapped
				endcase
			end
		end
	end

	// ack is only ever an answer to a live access
	a_ack_needs_access: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		$rose(o_wb_ack) |-> $past(access)
	);

endmodule

// File: logic/aprsc_sequencer.sv
// request sequencer: one predictor run per rising request level
// start kicks the mac, capture follows mac done, adapt comes two cycles
// later so the taps update after the result has been registered
module aprsc_sequencer
	import aprsc_dsp_pkg::*;
(
	input  logic CoPrclk_int,
	input  logic reset,
	input  logic i_req,
	input  logic i_done,
	output logic o_start,
	output logic o_capture,
	output logic o_adapt,
	output logic o_result_valid
);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_HOLD} state_t;

	state_t state;
	logic   done_dly;	// first stage of the adapt spacing

	assign o_capture = i_done;	// readback latches the fresh estimate

	always_ff @(posedge CoPrclk_int or posedge reset) begin
		if (reset) begin
			state          <= S_IDLE;
			o_start        <= 1'b0;
			o_result_valid <= 1'b0;
			done_dly       <= 1'b0;
			o_adapt        <= 1'b0;
		end else begin
			o_start  <= 1'b0;
			done_dly <= i_done;
			o_adapt  <= done_dly;	// two cycles after done
			case (state)
				S_IDLE: begin
					o_result_valid <= 1'b0;
					if (i_req) begin
						state   <= S_RUN;
						o_start <= 1'b1;
					end
				end
				S_RUN: begin
					if (i_done) begin
						state          <= S_HOLD;
						o_result_valid <= 1'b1;
					end
				end
				S_HOLD: begin
					if (!i_req)
						state <= S_IDLE;	// a new run needs req low first
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_done_in_run: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		i_done |-> state == S_RUN
	);

	// mac latency seen from here
	a_done_latency: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		o_start |-> ##(NUM_TAPS+1) i_done
	);

endmodule

// File: logic/zero_predictor_taps.sv
// storage of the zero predictor: past samples dq1..dq6 and coefficients
// b1..b6, read one pair at a time by the mac through the tap select
// on adapt every b_k gets leakage plus a sign-sign step and the history
// shifts in the current dq; a set trigger clears all coefficients
module zero_predictor_taps
	import aprsc_dsp_pkg::*;
(
	input  logic                 CoPrclk_int,
	input  logic                 reset,
	input  logic                 i_adapt,
	input  logic                 i_tr,
	input  sample_t              i_dq,
	input  logic [TAP_IDX_W-1:0] i_tap_sel,
	output sample_t              o_dq_hist,
	output coef_t                o_coef
);

	sample_t dq_hist   [NUM_TAPS];	// index 0 holds dq1
	coef_t   coef      [NUM_TAPS];	// index 0 holds b1
	coef_t   leak      [NUM_TAPS];
	coef_t   step      [NUM_TAPS];
	coef_t   coef_next [NUM_TAPS];

	//----------------------------------------------------------------------
	// tap readout for the mac
	//----------------------------------------------------------------------
	assign o_dq_hist = (i_tap_sel < NUM_TAPS) ? dq_hist[i_tap_sel] : '0;
	assign o_coef    = (i_tap_sel < NUM_TAPS) ? coef[i_tap_sel]    : '0;

	//----------------------------------------------------------------------
	// coefficient update
	//----------------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < NUM_TAPS; k++) begin
			leak[k] = coef[k] - (coef[k] >>> LEAK_SHIFT);
			if (i_dq == '0)
				step[k] = '0;	// no information, leakage only
			else if (i_dq[SAMPLE_W-1] == dq_hist[k][SAMPLE_W-1])
				step[k] = coef_t'(UPD_GAIN);	// zero counts as positive
			else
				step[k] = -coef_t'(UPD_GAIN);
			coef_next[k] = leak[k] + step[k];
		end
	end

	always_ff @(posedge CoPrclk_int or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_TAPS; k++) begin
				dq_hist[k] <= '0;
				coef[k]    <= '0;
			end
		end else if (i_adapt) begin
			for (int k = 0; k < NUM_TAPS; k++)
				coef[k] <= i_tr ? coef_t'(0) : coef_next[k];
			dq_hist[0] <= i_dq;
			for (int k = 1; k < NUM_TAPS; k++)
				dq_hist[k] <= dq_hist[k-1];	// dq_k takes dq_(k-1)
		end
	end

endmodule

// File: logic/zero_predictor_mac.sv
// tap-serial multiply-accumulate of the zero predictor
// walks the taps one per cycle after start, sums b_k*dq_k scaled down
// by the coefficient fraction, then saturates the sum into se
// done pulses NUM_TAPS+1 cycles after start
module zero_predictor_mac
	import aprsc_dsp_pkg::*;
(
	input  logic                 CoPrclk_int,
	input  logic                 reset,
	input  logic                 i_start,
	input  coef_t                i_coef,
	input  sample_t              i_dq_hist,
	output logic [TAP_IDX_W-1:0] o_tap_sel,
	output sample_t              o_se,
	output logic                 o_done
);

	logic                        busy;
	logic                        last;	// final tap this cycle
	logic signed [2*SAMPLE_W-1:0] prod;
	acc_t                        term;
	acc_t                        acc;
	acc_t                        sum_next;
	logic                        ovf;
	sample_t                     se_sat;

	assign last = busy && (o_tap_sel == TAP_IDX_W'(NUM_TAPS-1));

	//----------------------------------------------------------------------
	// datapath
	//----------------------------------------------------------------------
	assign prod     = i_coef * i_dq_hist;
	assign term     = acc_t'(prod >>> COEF_FRAC);	// drop coefficient fraction
	assign sum_next = acc + term;

	// sum fits when all bits above the sample sign agree
	assign ovf    = !((&sum_next[ACC_W-1:SAMPLE_W-1]) || !(|sum_next[ACC_W-1:SAMPLE_W-1]));
	assign se_sat = !ovf ? sample_t'(sum_next) :
			sum_next[ACC_W-1] ? {1'b1, {(SAMPLE_W-1){1'b0}}} :
			{1'b0, {(SAMPLE_W-1){1'b1}}};

	always_ff @(posedge CoPrclk_int) begin
		if (i_start)
			acc <= '0;
		else if (busy)
			acc <= sum_next;
	end

	//----------------------------------------------------------------------
	// tap sequencing
	//----------------------------------------------------------------------
	always_ff @(posedge CoPrclk_int or posedge reset) begin
		if (reset) begin
			busy      <= 1'b0;
			o_tap_sel <= '0;
			o_done    <= 1'b0;
			o_se      <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy      <= 1'b1;
				o_tap_sel <= '0;
			end else if (last) begin
				busy      <= 1'b0;
				o_tap_sel <= '0;
				o_se      <= se_sat;
				o_done    <= 1'b1;
			end else if (busy) begin
				o_tap_sel <= o_tap_sel + 1'b1;
			end
		end
	end

	// one run in flight at a time
	a_no_start_busy: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		i_start |-> !busy
	);

endmodule

// File: logic/aprsc_readback.sv
// bus output side of the coprocessor
// latches se and the reconstructed signal sr = dq + se when a run ends
// and loads the addressed word on the read strobe so it is valid with ack
module aprsc_readback
	import aprsc_bus_pkg::*;
	import aprsc_dsp_pkg::*;
(
	input  logic              CoPrclk_int,
	input  logic              reset,
	input  logic              i_capture,
	input  sample_t           i_se,
	input  sample_t           i_dq,
	input  logic              i_result_valid,
	input  logic              i_rd_stb,
	input  logic [ADR_W-1:0]  i_wb_adr,
	output logic [BUS_DW-1:0] o_wb_dat
);

	logic signed [SAMPLE_W:0] sr_sum;	// one guard bit
	sample_t                  sr_sat;
	sample_t                  se_q;
	sample_t                  sr_q;

	assign sr_sum = {i_dq[SAMPLE_W-1], i_dq} + {i_se[SAMPLE_W-1], i_se};
	assign sr_sat = (sr_sum[SAMPLE_W] == sr_sum[SAMPLE_W-1]) ? sample_t'(sr_sum) :
			sr_sum[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}} :
			{1'b0, {(SAMPLE_W-1){1'b1}}};

	always_ff @(posedge CoPrclk_int or posedge reset) begin
		if (reset) begin
			se_q     <= '0;
			sr_q     <= '0;
			o_wb_dat <= '0;
		end else begin
			if (i_capture) begin
				se_q <= i_se;
				sr_q <= sr_sat;
			end
			if (i_rd_stb) begin
				case (i_wb_adr)
					ADR_STATUS: o_wb_dat <= {{(BUS_DW-1){1'b0}}, i_result_valid};
					ADR_SE:     o_wb_dat <= {{(BUS_DW-SAMPLE_W){se_q[SAMPLE_W-1]}}, se_q};
					ADR_SR:     o_wb_dat <= {{(BUS_DW-SAMPLE_W){sr_q[SAMPLE_W-1]}}, sr_q};
					default:    o_wb_dat <= RD_DEFAULT;
				endcase
			end
		end
	end

endmodule

// File: logic/aprsc_top.sv
// adaptive zero predictor coprocessor, wishbone slave
// bus registers feed the sequencer and the predictor, the readback
// block returns status and results; all logic runs on CoPrclk_int
module aprsc_top
	import aprsc_bus_pkg::*;
	import aprsc_dsp_pkg::*;
(
	input  logic                CoPrclk_int,
	input  logic                reset,
	input  logic [31:0]         i_wb_adr,	// low ADR_W bits decoded
	input  logic [BUS_DW/8-1:0] i_wb_sel,	// byte lanes, not used
	input  logic                i_wb_we,
	input  logic [BUS_DW-1:0]   i_wb_dat,
	input  logic                i_wb_cyc,
	input  logic                i_wb_stb,
	output logic [BUS_DW-1:0]   o_wb_dat,
	output logic                o_wb_ack
);

	logic                 req, tr, rd_stb;
	sample_t              dq;
	logic                 start, capture, adapt, result_valid;
	logic                 done;
	logic [TAP_IDX_W-1:0] tap_sel;
	sample_t              dq_hist;
	coef_t                coef;
	sample_t              se;

	//----------------------------------------------------------------------
	// input side
	//----------------------------------------------------------------------
	aprsc_bus_regs u_bus_regs (
		.CoPrclk_int (CoPrclk_int),
		.reset       (reset),
		.i_wb_adr    (i_wb_adr[ADR_W-1:0]),
		.i_wb_we     (i_wb_we),
		.i_wb_dat    (i_wb_dat),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.o_wb_ack    (o_wb_ack),
		.o_req       (req),
		.o_tr        (tr),
		.o_dq        (dq),
		.o_rd_stb    (rd_stb)
	);

	//----------------------------------------------------------------------
	// processing
	//----------------------------------------------------------------------
	aprsc_sequencer u_sequencer (
		.CoPrclk_int    (CoPrclk_int),
		.reset          (reset),
		.i_req          (req),
		.i_done         (done),
		.o_start        (start),
		.o_capture      (capture),
		.o_adapt        (adapt),
		.o_result_valid (result_valid)
	);

	zero_predictor_taps u_taps (
		.CoPrclk_int (CoPrclk_int),
		.reset       (reset),
		.i_adapt     (adapt),
		.i_tr        (tr),
		.i_dq        (dq),
		.i_tap_sel   (tap_sel),
		.o_dq_hist   (dq_hist),
		.o_coef      (coef)
	);

	zero_predictor_mac u_mac (
		.CoPrclk_int (CoPrclk_int),
		.reset       (reset),
		.i_start     (start),
		.i_coef      (coef),
		.i_dq_hist   (dq_hist),
		.o_tap_sel   (tap_sel),
		.o_se        (se),
		.o_done      (done)
	);

	//----------------------------------------------------------------------
	// output side
	//----------------------------------------------------------------------
	aprsc_readback u_readback (
		.CoPrclk_int    (CoPrclk_int),
		.reset          (reset),
		.i_capture      (capture),
		.i_se           (se),
		.i_dq           (dq),
		.i_result_valid (result_valid),
		.i_rd_stb       (rd_stb),
		.i_wb_adr       (i_wb_adr[ADR_W-1:0]),
		.o_wb_dat       (o_wb_dat)
	);

endmodule

// File: sim/aprsc_tb.sv
// testbench for the adaptive zero predictor coprocessor
// drives the wishbone port with single accesses, runs estimates and
// compares SE and SR against a reference model of the predictor
// checks are assertions, a cycle counter stops a stuck run
module aprsc_tb
	import aprsc_bus_pkg::*;
	import aprsc_dsp_pkg::*;
();

	localparam int CYCLE_LIMIT = 2000;	// about twice the full test length

	logic        CoPrclk_int;
	logic        reset;
	logic [31:0] i_wb_adr;
	logic [3:0]  i_wb_sel;
	logic        i_wb_we;
	logic [31:0] i_wb_dat;
	logic        i_wb_cyc;
	logic        i_wb_stb;
	logic [31:0] o_wb_dat;
	logic        o_wb_ack;

	integer      seed = 32'ha618_f4fa;
	int          cycle_count = 0;
	int          errors = 0;
	int          errors_before = 0;	// error count when the current test began
	int          tests_run = 0;
	int          tests_failed = 0;
	int          sat_count = 0;	// saturated results seen
	int          model_hist [NUM_TAPS];	// index 0 is dq1
	int          model_coef [NUM_TAPS];
	logic [31:0] last_se;
	logic [31:0] last_sr;

	aprsc_top uut (
		.CoPrclk_int (CoPrclk_int),
		.reset       (reset),
		.i_wb_adr    (i_wb_adr),
		.i_wb_sel    (i_wb_sel),
		.i_wb_we     (i_wb_we),
		.i_wb_dat    (i_wb_dat),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack)
	);

	initial begin
		CoPrclk_int = 1'b0;
		forever #20 CoPrclk_int = ~CoPrclk_int;
	end

	always @(posedge CoPrclk_int) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// bus protocol checks
	//----------------------------------------------------------------------
	a_ack_one_cycle: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		o_wb_ack |=> !o_wb_ack
	) else begin
		$display("ack stayed high for more than one cycle");
		errors++;
	end

	a_ack_after_access: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		$rose(i_wb_cyc & i_wb_stb) |=> o_wb_ack
	) else begin
		$display("access was not acknowledged in the following cycle");
		errors++;
	end

	a_ack_with_access: assert property (
		@(posedge CoPrclk_int) disable iff (reset)
		o_wb_ack |-> $past(i_wb_cyc & i_wb_stb)
	) else begin
		$display("ack without a bus access");
		errors++;
	end

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	function automatic int saturate16(input int x);
		if (x > 32767)
			return 32767;
		if (x < -32768)
			return -32768;
		return x;
	endfunction

	function automatic int wrap16(input int x);
		logic signed [15:0] w;
		w = x[15:0];
		return int'(w);
	endfunction

	function automatic int predict_se();
		int sum;
		sum = 0;
		for (int k = 0; k < NUM_TAPS; k++)
			sum += (model_coef[k] * model_hist[k]) >>> COEF_FRAC;
		return saturate16(sum);
	endfunction

	task automatic update_model(input int dq, input bit tr);
		int leak;
		int step;
		for (int k = 0; k < NUM_TAPS; k++) begin
			leak = model_coef[k] - (model_coef[k] >>> LEAK_SHIFT);
			if (dq == 0)
				step = 0;
			else if ((dq < 0) == (model_hist[k] < 0))
				step = UPD_GAIN;	// zero history counts as positive
			else
				step = -UPD_GAIN;
			model_coef[k] = tr ? 0 : wrap16(leak + step);
		end
		for (int k = NUM_TAPS - 1; k > 0; k--)
			model_hist[k] = model_hist[k-1];
		model_hist[0] = dq;
	endtask

	//----------------------------------------------------------------------
	// bus access, entered and left 2 units after a rising edge
	//----------------------------------------------------------------------
	task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
			input logic [31:0] wdat, input int hold, output logic [31:0] rdat);
		i_wb_adr = {16'h0000, adr};
		i_wb_we  = we;
		i_wb_dat = wdat;
		i_wb_sel = 4'hF;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		do begin
			@(posedge CoPrclk_int);
			#2;
		end while (o_wb_ack !== 1'b1);
		rdat = o_wb_dat;
		repeat (hold) begin
			@(posedge CoPrclk_int);	// master keeps cyc and stb up after ack
			#2;
		end
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		@(posedge CoPrclk_int);	// idle cycle between accesses
		#2;
	endtask

	task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, wdat, 0, unused);
	endtask

	task automatic read_reg(input logic [ADR_W-1:0] adr, output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, 0, rdat);
	endtask

	task automatic read_held(input logic [ADR_W-1:0] adr, input int hold,
			output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, hold, rdat);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	endtask

	task automatic close_test(input int num, input string name);
		tests_run++;
		if (errors > errors_before) begin
			tests_failed++;
			$display("test %0d %s: FAILED", num, name);
		end else begin
			$display("test %0d %s: ok", num, name);
		end
		errors_before = errors;
	endtask

	//----------------------------------------------------------------------
	// one estimate: load dq, raise req, wait for done, check, drop req
	//----------------------------------------------------------------------
	task automatic start_run(input int dq);
		logic [31:0] status;
		write_reg(ADR_DQ, 32'(dq));
		write_reg(ADR_REQ, 32'h1);
		do
			read_reg(ADR_STATUS, status);
		while (status[0] !== 1'b1);	// the cycle counter bounds this
	endtask

	task automatic finish_run(input int dq, input bit tr);
		int exp_se;
		int exp_sr;
		exp_se = predict_se();
		exp_sr = saturate16(dq + exp_se);
		read_reg(ADR_SE, last_se);
		read_reg(ADR_SR, last_sr);
		a_se_model: assert (last_se == 32'(exp_se))
			else report_mismatch("SE", last_se, 32'(exp_se));
		a_sr_model: assert (last_sr == 32'(exp_sr))
			else report_mismatch("SR", last_sr, 32'(exp_sr));
		if (exp_sr == 32767 || exp_sr == -32768 || exp_se == 32767 || exp_se == -32768)
			sat_count++;
		update_model(dq, tr);
		write_reg(ADR_REQ, 32'h0);
	endtask

	//----------------------------------------------------------------------
	// test sequence
	//----------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		int          dq;
		int          mag;
		i_wb_adr = '0;
		i_wb_sel = '0;
		i_wb_we  = 1'b0;
		i_wb_dat = '0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		reset    = 1'b1;
		for (int k = 0; k < NUM_TAPS; k++) begin
			model_hist[k] = 0;
			model_coef[k] = 0;
		end
		repeat (2) @(posedge CoPrclk_int);
		#2;
		reset = 1'b0;

		// reset values and the default read word
		read_reg(ADR_STATUS, rd);
		a_status_rst: assert (rd == 32'h0) else report_mismatch("STATUS", rd, 32'h0);
		write_reg(ADR_SE, 32'h0000_1234);	// read-only, must be ignored
		read_reg(ADR_SE, rd);
		a_se_rst: assert (rd == 32'h0) else report_mismatch("SE", rd, 32'h0);
		read_reg(ADR_SR, rd);
		a_sr_rst: assert (rd == 32'h0) else report_mismatch("SR", rd, 32'h0);
		read_reg(16'h0020, rd);
		a_unknown: assert (rd == 32'hDEAD_BEEF)
			else report_mismatch("o_wb_dat", rd, 32'hDEAD_BEEF);
		close_test(1, "reset values");

		// written dq reaches the reconstructed signal
		dq = 16'sh1234;
		start_run(dq);
		finish_run(dq, 1'b0);
		// coefficients are still zero, so se is 0 and sr is dq
		a_sr_dq: assert (last_sr == 32'(dq))
			else report_mismatch("SR", last_sr, 32'(dq));
		read_held(ADR_SR, 3, rd);	// long access still gets a single ack
		a_sr_held: assert (rd == 32'(dq)) else report_mismatch("SR", rd, 32'(dq));
		close_test(2, "bus writes and ack");

		// done flag follows the request level
		dq = -5000;
		start_run(dq);
		for (int i = 0; i < 3; i++) begin
			repeat (4) @(posedge CoPrclk_int);
			#2;
			read_reg(ADR_STATUS, rd);
			a_done_held: assert (rd == 32'h1) else report_mismatch("STATUS", rd, 32'h1);
		end
		finish_run(dq, 1'b0);
		for (int i = 0; i < 4; i++) begin
			read_reg(ADR_STATUS, rd);
			if (rd[0] == 1'b0)
				break;
		end
		a_done_clear: assert (rd == 32'h0) else report_mismatch("STATUS", rd, 32'h0);
		close_test(3, "status flag");

		// alternating signs grow the coefficients toward saturation
		for (int i = 0; i < 40; i++) begin
			mag = $random(seed) & 32'h7FFF;
			dq  = (i % 2) ? -mag : mag;
			start_run(dq);
			finish_run(dq, 1'b0);
		end
		$display("random samples: %0d saturated results", sat_count);
		a_saturated: assert (sat_count > 0) else begin
			$display("no saturated result was reached by the random samples");
			errors++;
		end
		close_test(4, "random samples");

		// trigger clears the coefficients on the next adaptation
		write_reg(ADR_TR, 32'h1);
		dq = 12000;
		start_run(dq);
		finish_run(dq, 1'b1);
		write_reg(ADR_TR, 32'h0);
		dq = -9000;
		start_run(dq);
		finish_run(dq, 1'b0);
		a_se_cleared: assert (last_se == 32'h0) else report_mismatch("SE", last_se, 32'h0);
		close_test(5, "trigger reset");

		// a request held high adapts only once
		dq = 15000;
		start_run(dq);
		repeat (30) @(posedge CoPrclk_int);
		#2;
		read_reg(ADR_STATUS, rd);
		a_hold_done: assert (rd == 32'h1) else report_mismatch("STATUS", rd, 32'h1);
		finish_run(dq, 1'b0);
		dq = -7000;
		start_run(dq);
		finish_run(dq, 1'b0);
		close_test(6, "held request");

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: project.f
logic/aprsc_bus_pkg.sv
logic/aprsc_dsp_pkg.sv
logic/aprsc_bus_regs.sv
logic/aprsc_sequencer.sv
logic/zero_predictor_taps.sv
logic/zero_predictor_mac.sv
logic/aprsc_readback.sv
logic/aprsc_top.sv
sim/aprsc_tb.sv

// File: Bender.yml
package:
  name: aprsc

sources:
  - logic/aprsc_bus_pkg.sv
  - logic/aprsc_dsp_pkg.sv
  - logic/aprsc_bus_regs.sv
  - logic/aprsc_sequencer.sv
  - logic/zero_predictor_taps.sv
  - logic/zero_predictor_mac.sv
  - logic/aprsc_readback.sv
  - logic/aprsc_top.sv
  - target: test
    files:
      - sim/aprsc_tb.sv
